/* flist.f */
vdp_pkg.sv
vdp_if.sv
vdp_reg_ifce.sv
vram.sv
vgasync.sv
vdp_fsm.sv
vdp99.sv
tb_vdp99.sv

/* run_sim.sh */
#!/bin/sh
# build the vdp99 testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_vdp99 -f flist.f -o tb_vdp99_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_vdp99_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASSED" sim.log; then
    exit 0
fi
echo "no pass line found in sim.log"
exit 1

/* tb_vdp99.sv */
// vdp testbench driving CPU ticks with xorshift data and checking VRAM, syncs, picture and irq
module tb_vdp99 import vdp_pkg::*; ();

    localparam int VRAM_SIZE    = 8192;
    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYC    = 16;
    localparam int DRIVE_DLY    = 1;     // inputs change this long after the rising edge
    localparam int CPU_GAP      = 6;     // clocks from one CPU tick to the next
    localparam int FRAME_CYC    = int'(H_TOTAL) * int'(V_TOTAL);
    localparam int CPU_ACCESSES = 3200;  // round trip, table fill and register pairs, rounded up
    // sync, blanking, picture and irq phases take a little over six frames, two more are slack
    localparam int WATCHDOG_CYC = 8 * FRAME_CYC + CPU_ACCESSES * CPU_GAP;

    logic       pxclk;
    logic       rst_n;
    logic       wr_tick;
    logic       rd_tick;
    logic       mode;
    logic [7:0] din;
    logic [7:0] dout;
    logic       irq;
    color_t     color;
    logic       hsync;
    logic       vsync;

    logic [7:0]  vram_model [VRAM_SIZE];  // what the CPU has written so far
    logic [7:0]  reg_model [8];
    int          ptr_model;               // CPU address pointer as the DUT should hold it
    logic [31:0] rng;
    int          n_checks;
    int          n_errors;
    time         t0;
    time         t1;
    time         t2;
    logic [7:0]  rd_byte;
    int          addr;
    int          offset;
    int          step;
    int          x;
    int          y;
    logic        seen_bad;

    vdp99 #(.VRAM_SIZE(VRAM_SIZE)) dut_i (
        .pxclk(pxclk), .rst_n(rst_n), .wr_tick(wr_tick), .rd_tick(rd_tick), .mode(mode),
        .din(din), .dout(dout), .irq(irq), .color(color), .hsync(hsync), .vsync(vsync)
    );

    always #(CLK_PERIOD / 2) pxclk = ~pxclk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        return v ^ (v << 5);
    endfunction

    // ****************************************
    // compare tasks, one per result type
    // ****************************************
    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %s got 0x%02h expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_color(input string name, input color_t got, input color_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %s got 0x%01h expected 0x%01h at x %0d y %0d", name, got, exp, x, y);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %s got 0x%01h expected 0x%01h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        n_checks++;
        if (got != exp) begin
            n_errors++;
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // ****************************************
    // CPU port access and model upkeep
    // ****************************************
    task automatic cpu_write(input logic m, input logic [7:0] d);
        @(posedge pxclk);
        #DRIVE_DLY;
        mode    = m;
        din     = d;
        wr_tick = 1'b1;
        @(posedge pxclk);
        #DRIVE_DLY;
        wr_tick = 1'b0;
        repeat (CPU_GAP - 2) @(posedge pxclk);
    endtask

    task automatic cpu_read(input logic m, output logic [7:0] d);
        @(posedge pxclk);
        #DRIVE_DLY;
        mode    = m;
        rd_tick = 1'b1;
        @(negedge pxclk);
        d = dout;  // valid during the tick cycle
        @(posedge pxclk);
        #DRIVE_DLY;
        rd_tick = 1'b0;
        repeat (CPU_GAP - 2) @(posedge pxclk);
    endtask

    task automatic write_reg(input int n, input logic [7:0] value);
        ctrl_byte_u cb;
        cb = '0;
        cb.reg_wr.is_reg = 1'b1;
        cb.reg_wr.regnum = 3'(n);
        cpu_write(1'b1, value);  // value goes first, register number second
        cpu_write(1'b1, cb);
        reg_model[n] = value;
    endtask

    task automatic set_addr(input int a, input logic wr_intent);
        ctrl_byte_u cb;
        cb = '0;
        cb.addr_ld.wr_intent = wr_intent;
        cb.addr_ld.addr_hi   = 6'(a >> 8);
        cpu_write(1'b1, 8'(a));
        cpu_write(1'b1, cb);
        ptr_model = a;
    endtask

    task automatic fill_random(input int base, input int len);
        set_addr(base, 1'b1);
        repeat (len) begin
            rng = xorshift32(rng);
            cpu_write(1'b0, rng[7:0]);
            vram_model[ptr_model] = rng[7:0];
            ptr_model = (ptr_model + 1) % VRAM_SIZE;
        end
    endtask

    task automatic read_compare();
        logic [7:0] got;
        cpu_read(1'b0, got);
        check_byte("dout", got, vram_model[ptr_model]);
        ptr_model = (ptr_model + 1) % VRAM_SIZE;
    endtask

    // Graphics I rule, each pattern pixel covers two clocks and two lines
    function automatic color_t expected_color(input int px_x, input int px_y);
        int         px;
        int         py;
        int         name;
        logic [7:0] pat;
        logic [7:0] colr;
        color_t     nib;
        if (px_x < int'(PIC_X0) || px_x >= int'(PIC_X0 + PIC_W) ||
            px_y < int'(PIC_Y0) || px_y >= int'(PIC_Y0 + PIC_H)) begin
            return reg_model[7][3:0];  // border shows the backdrop
        end
        px   = (px_x - int'(PIC_X0)) / 2;
        py   = (px_y - int'(PIC_Y0)) / 2;
        name = vram_model[int'(reg_model[2][3:0]) * 1024 + (py / 8) * 32 + px / 8];
        pat  = vram_model[int'(reg_model[4][2:0]) * 2048 + name * 8 + py % 8];
        colr = vram_model[int'(reg_model[3]) * 64 + name / 8];  // one colour byte per 8 names
        nib  = pat[7 - px % 8] ? colr[7:4] : colr[3:0];
        return (nib == 4'd0) ? reg_model[7][3:0] : nib;
    endfunction

    initial begin
        pxclk    = 1'b0;
        rst_n    = 1'b0;
        wr_tick  = 1'b0;
        rd_tick  = 1'b0;
        mode     = 1'b0;
        din      = 8'd0;
        rng      = 32'd39;
        n_checks = 0;
        n_errors = 0;
        for (int i = 0; i < 8; i++) reg_model[i] = 8'd0;
        repeat (RESET_CYC - 1) @(posedge pxclk);
        @(negedge pxclk);
        check_bit("hsync", hsync, 1'b1);  // idle outputs while in reset
        check_bit("vsync", vsync, 1'b1);
        check_bit("irq", irq, 1'b0);
        check_color("color", color, 4'd0);
        @(posedge pxclk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        // round trip through the pointer increment and the read-ahead buffer
        rng  = xorshift32(rng);
        addr = int'(rng[12:0]);
        fill_random(addr, 64);
        set_addr(addr, 1'b0);
        repeat (64) read_compare();

        // sync geometry measured at the pins
        @(negedge hsync);
        t0 = $time;
        @(posedge hsync);
        t1 = $time;
        @(negedge hsync);
        t2 = $time;
        check_count("hsync low clocks", int'((t1 - t0) / CLK_PERIOD), int'(H_SYNC_WIDTH));
        check_count("hsync period clocks", int'((t2 - t0) / CLK_PERIOD), int'(H_TOTAL));
        @(negedge vsync);
        t0 = $time;
        @(posedge vsync);
        t1 = $time;
        @(negedge vsync);
        t2 = $time;
        check_count("vsync low clocks", int'((t1 - t0) / CLK_PERIOD),
                    int'(V_SYNC_WIDTH) * int'(H_TOTAL));
        check_count("vsync period clocks", int'((t2 - t0) / CLK_PERIOD), FRAME_CYC);

        // tables placed apart: names at 6K, patterns at 2K, colours at 1K
        write_reg(2, 8'h06);
        write_reg(3, 8'h10);
        write_reg(4, 8'h01);
        rng = xorshift32(rng);
        write_reg(7, rng[7:0] | 8'h01);  // odd backdrop, so an unblanked border is never black
        fill_random(6 * 1024, 768);
        fill_random(2048, 2048);
        fill_random(1024, 32);

        // blank-enable still 0 after reset, so a whole frame must stay black
        seen_bad = 1'b0;
        repeat (FRAME_CYC) begin
            @(negedge pxclk);
            if (color !== 4'd0 && !seen_bad) begin
                check_color("color", color, 4'd0);
                seen_bad = 1'b1;
            end
        end

        write_reg(1, 8'h40);  // display on, interrupt off

        // the pin vsync edge already carries the pipeline delay, so offset 0 is line 490 col 0
        @(negedge vsync);
        offset = 0;
        @(negedge pxclk);
        while (offset < FRAME_CYC) begin
            x = offset % int'(H_TOTAL);
            y = (offset / int'(H_TOTAL) + int'(V_SYNC_START)) % int'(V_TOTAL);
            if (x < int'(H_ACTIVE) && y < int'(V_ACTIVE)) begin
                check_color("color", color, expected_color(x, y));
            end
            rng  = xorshift32(rng);
            step = 1 + int'(rng % 32'd1200);
            repeat (step) @(negedge pxclk);
            offset += step;
        end

        // ****************************************
        // frame interrupt
        // ****************************************
        write_reg(1, 8'h60);
        cpu_read(1'b1, rd_byte);  // drops the flag left by earlier frames
        @(negedge pxclk);
        check_bit("irq", irq, 1'b0);
        step = 0;
        while (irq !== 1'b1 && step < FRAME_CYC + 100) begin
            @(negedge pxclk);
            step++;
        end
        if (irq !== 1'b1) begin
            n_errors++;
            $display("irq did not rise within one frame with interrupts enabled");
        end
        cpu_read(1'b1, rd_byte);
        check_byte("status", rd_byte, 8'h80);
        @(negedge pxclk);
        check_bit("irq", irq, 1'b0);  // the status read clears it

        write_reg(1, 8'h40);
        cpu_read(1'b1, rd_byte);
        seen_bad = 1'b0;
        repeat (FRAME_CYC + 100) begin
            @(negedge pxclk);
            if (irq !== 1'b0 && !seen_bad) begin
                check_bit("irq", irq, 1'b0);
                seen_bad = 1'b1;
            end
        end
        cpu_read(1'b1, rd_byte);
        check_byte("status", rd_byte, 8'h80);  // flag still sets with irq masked

        $display("checks %0d errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("watchdog expired after %0d clocks before the tests finished", WATCHDOG_CYC);
        $display("checks %0d errors %0d", n_checks, n_errors);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* vdp99.sv */
// vdp top level joining the CPU port, VRAM, raster timing and Graphics I renderer
module vdp99 import vdp_pkg::*; #(
    parameter int VRAM_SIZE = 8192
) (
    input  logic       pxclk,     // 25 MHz pixel clock
    input  logic       rst_n,
    input  logic       wr_tick,   // one clock per CPU write
    input  logic       rd_tick,   // one clock per CPU read
    input  logic       mode,      // 0 VRAM data, 1 control and status
    input  logic [7:0] din,
    output logic [7:0] dout,      // valid during rd_tick
    output logic       irq,
    output color_t     color,
    output logic       hsync,
    output logic       vsync
);

    localparam int AW = $clog2(VRAM_SIZE);

    vram_cpu_if cpu_bus ();
    vdp_cfg_if  cfg_bus ();

    logic [7:0]    status;
    logic [AW-1:0] dma_addr;
    logic [7:0]    dma_data;
    logic [9:0]    col;
    logic [9:0]    row;
    logic          hs_raw;
    logic          vs_raw;
    logic          vid_active;
    logic          bdr_active;
    logic          end_of_frame;
    logic          vid_active_out;
    logic          bdr_active_out;
    color_t        pic_color;

    vdp_reg_ifce u_regs (
        .pxclk(pxclk), .rst_n(rst_n), .wr_tick(wr_tick), .rd_tick(rd_tick), .mode(mode),
        .din(din), .frame_tick(end_of_frame), .status(status), .irq(irq),
        .cpu(cpu_bus), .cfg(cfg_bus)
    );

    vram #(.VRAM_SIZE(VRAM_SIZE)) u_vram (
        .pxclk(pxclk), .rst_n(rst_n), .dma_addr(dma_addr), .dma_data(dma_data), .cpu(cpu_bus)
    );

    vgasync u_sync (
        .pxclk(pxclk), .rst_n(rst_n), .col(col), .row(row), .hsync(hs_raw), .vsync(vs_raw),
        .vid_active(vid_active), .bdr_active(bdr_active), .end_of_frame(end_of_frame)
    );

    vdp_fsm #(.VRAM_SIZE(VRAM_SIZE)) u_fsm (
        .pxclk(pxclk), .rst_n(rst_n), .px_col(col), .px_row(row), .hsync(hs_raw),
        .vsync(vs_raw), .vid_active(vid_active), .bdr_active(bdr_active),
        .vram_data(dma_data), .cfg(cfg_bus), .dma_addr(dma_addr), .hsync_out(hsync),
        .vsync_out(vsync), .vid_active_out(vid_active_out),
        .bdr_active_out(bdr_active_out), .color_out(pic_color)
    );

    assign dout = mode ? status : cpu_bus.rdata;

    // ****************************************
    // output colour select
    // ****************************************
    always_comb begin
        color = 4'd0;  // black outside the visible area or while blanked
        if (cfg_bus.blank_en) begin
            if (bdr_active_out) begin
                color = cfg_bus.bg_color;
            end else if (vid_active_out) begin
                color = pic_color;
            end
        end
    end

endmodule

/* vdp_fsm.sv */
// vdp Graphics I renderer with per-cell name, pattern and colour fetch and pixel shifter
module vdp_fsm import vdp_pkg::*; #(
    parameter int VRAM_SIZE = 8192
) (
    input  logic                         pxclk,
    input  logic                         rst_n,
    input  logic [9:0]                   px_col,
    input  logic [9:0]                   px_row,
    input  logic                         hsync,
    input  logic                         vsync,
    input  logic                         vid_active,
    input  logic                         bdr_active,
    input  logic [7:0]                   vram_data,   // one clock behind dma_addr
    vdp_cfg_if.sink                      cfg,
    output logic [$clog2(VRAM_SIZE)-1:0] dma_addr,
    output logic                         hsync_out,
    output logic                         vsync_out,
    output logic                         vid_active_out,
    output logic                         bdr_active_out,
    output color_t                       color_out
);

    localparam int AW = $clog2(VRAM_SIZE);

    logic [9:0]  fx;          // column shifted one cell ahead of the picture
    logic [9:0]  py;          // row inside the picture
    logic [3:0]  phase;       // clock within the 16-clock cell
    logic [4:0]  fcell;       // cell being fetched
    logic [4:0]  crow;        // character row
    logic [2:0]  pline;       // pattern line, each one spans two rows
    logic [13:0] name_addr;
    logic [13:0] pat_addr;
    logic [13:0] colr_addr;
    logic [7:0]  name_q;
    logic [7:0]  pat_q;
    logic [7:0]  colr_q;
    logic [7:0]  shifter;
    logic [7:0]  colr_sh;     // colour byte of the cell on screen
    color_t      pix_nib;
    logic [PIPE_DELAY-1:0][3:0] sync_dly;

    // fetching runs one cell early so cell 0 is read during the last border cell
    assign fx    = px_col - (PIC_X0 - 10'd16);
    assign py    = px_row - PIC_Y0;
    assign phase = fx[3:0];
    assign fcell = fx[8:4];
    assign crow  = py[8:4];
    assign pline = py[3:1];

    assign name_addr = (14'(cfg.name_base) << NAME_SHIFT) + 14'({crow, fcell});
    assign pat_addr  = (14'(cfg.pattern_base) << PATTERN_SHIFT) + 14'({vram_data, pline});
    assign colr_addr = (14'(cfg.color_base) << COLOR_SHIFT) + 14'(name_q[7:3]);  // 8 names share one entry

    // ****************************************
    // fetch sequence, three reads per cell
    // ****************************************
    always_ff @(posedge pxclk) begin
        case (phase)
            4'd2: dma_addr <= AW'(name_addr);
            4'd4: begin
                name_q   <= vram_data;        // name byte arrives
                dma_addr <= AW'(pat_addr);    // and picks the pattern line at once
            end
            4'd5: dma_addr <= AW'(colr_addr);
            4'd6: pat_q  <= vram_data;
            4'd7: colr_q <= vram_data;
            default: ;
        endcase
    end

    // load lands on the third clock of the cell so the colour register ends up
    // exactly PIPE_DELAY behind the counters, then one bit per two clocks
    always_ff @(posedge pxclk) begin
        if (phase == 4'd1) begin
            shifter <= pat_q;
            colr_sh <= colr_q;
        end else if (phase[0]) begin
            shifter <= shifter << 1;
        end
    end

    // set bits take the high nibble, colour 0 shows the backdrop
    assign pix_nib = shifter[7] ? colr_sh[7:4] : colr_sh[3:0];

    always_ff @(posedge pxclk) begin
        color_out <= (pix_nib == 4'd0) ? cfg.bg_color : pix_nib;
    end

    // ****************************************
    // sync and window delay line
    // ****************************************
    always_ff @(posedge pxclk) begin
        if (!rst_n) begin
            sync_dly <= {PIPE_DELAY{4'b1100}};  // syncs idle high, windows closed
        end else begin
            sync_dly <= {sync_dly[PIPE_DELAY-2:0], hsync, vsync, vid_active, bdr_active};
        end
    end

    assign {hsync_out, vsync_out, vid_active_out, bdr_active_out} = sync_dly[PIPE_DELAY-1];

endmodule

/* vgasync.sv */
// vdp 640x480 raster counters with syncs, picture and border windows and frame end pulse
module vgasync import vdp_pkg::*; (
    input  logic       pxclk,
    input  logic       rst_n,
    output logic [9:0] col,
    output logic [9:0] row,
    output logic       hsync,         // active low
    output logic       vsync,         // active low
    output logic       vid_active,    // inside the 512x384 picture
    output logic       bdr_active,    // visible but outside the picture
    output logic       end_of_frame   // last pixel of the last line
);

    logic col_last;
    logic row_last;
    logic visible;

    assign col_last = (col == H_TOTAL - 10'd1);
    assign row_last = (row == V_TOTAL - 10'd1);

    // ****************************************
    // raster counters
    // ****************************************
    always_ff @(posedge pxclk) begin
        if (!rst_n) begin
            col <= '0;
            row <= '0;
        end else if (col_last) begin
            col <= '0;
            row <= row_last ? '0 : row + 10'd1;  // rows step once per line
        end else begin
            col <= col + 10'd1;
        end
    end

    // the syncs follow the counters directly and the renderer delays them
    assign hsync = ~((col >= H_SYNC_START) && (col < H_SYNC_START + H_SYNC_WIDTH));
    assign vsync = ~((row >= V_SYNC_START) && (row < V_SYNC_START + V_SYNC_WIDTH));

    assign visible = (col < H_ACTIVE) && (row < V_ACTIVE);

    // picture window, the border is the visible area left around it
    assign vid_active = (col >= PIC_X0) && (col < PIC_X0 + PIC_W) &&
                        (row >= PIC_Y0) && (row < PIC_Y0 + PIC_H);
    assign bdr_active = visible & ~vid_active;

    assign end_of_frame = col_last & row_last;

endmodule

/* vram.sv */
// vdp video memory with auto-incrementing CPU pointer, read-ahead buffer and renderer port
module vram #(
    parameter int VRAM_SIZE = 8192
) (
    input  logic                         pxclk,
    input  logic                         rst_n,
    input  logic [$clog2(VRAM_SIZE)-1:0] dma_addr,  // renderer fetch address
    output logic [7:0]                   dma_data,  // valid one clock after dma_addr
    vram_cpu_if.mem                      cpu
);

    localparam int AW = $clog2(VRAM_SIZE);

    logic [7:0]    mem [VRAM_SIZE];
    logic [AW-1:0] cpu_addr;  // next byte the CPU touches
    logic [AW-1:0] addr_inc;
    logic          refill;    // read-ahead due this clock
    logic [7:0]    read_buf;

    // wrap explicitly so sizes that are not a power of two still work
    assign addr_inc = (cpu_addr == AW'(VRAM_SIZE - 1)) ? '0 : cpu_addr + 1'b1;

    // ****************************************
    // CPU pointer
    // ****************************************
    always_ff @(posedge pxclk) begin
        if (!rst_n) begin
            cpu_addr <= '0;
            refill   <= 1'b0;
        end else begin
            refill <= 1'b0;
            if (cpu.addr_load) begin
                cpu_addr <= cpu.load_addr[AW-1:0];
                refill   <= cpu.load_read;  // read setup primes the buffer
            end else if (cpu.data_wr) begin
                cpu_addr <= addr_inc;
            end else if (cpu.data_rd) begin
                cpu_addr <= addr_inc;
                refill   <= 1'b1;  // fetch from the incremented address next clock
            end
        end
    end

    // two independent ports, the renderer never waits on the CPU
    always_ff @(posedge pxclk) begin
        if (cpu.data_wr) mem[cpu_addr] <= cpu.wdata;
        if (refill) read_buf <= mem[cpu_addr];
        dma_data <= mem[dma_addr];
    end

    assign cpu.rdata = read_buf;  // a data read returns what was prefetched

endmodule

/* vdp_reg_ifce.sv */
// vdp CPU port decoder holding the control pair latch, R0..R7, the frame flag and irq
module vdp_reg_ifce import vdp_pkg::*; (
    input  logic       pxclk,
    input  logic       rst_n,
    input  logic       wr_tick,
    input  logic       rd_tick,
    input  logic       mode,        // 0 data port, 1 control/status port
    input  logic [7:0] din,
    input  logic       frame_tick,  // one clock at the end of each frame
    output logic [7:0] status,
    output logic       irq,
    vram_cpu_if.ctrl   cpu,
    vdp_cfg_if.src     cfg
);

    logic [7:0] regs [8];
    logic [7:0] first_byte;   // low half of the control pair
    logic       pair_half;    // set once the first control byte is in
    logic       frame_flag;   // status bit 7
    ctrl_byte_u cb;
    logic       ctrl_wr;
    logic       stat_rd;
    logic       second;

    assign cb      = din;  // only meaningful on the second control byte
    assign ctrl_wr = wr_tick & mode;
    assign stat_rd = rd_tick & mode;
    assign second  = ctrl_wr & pair_half;

    // ****************************************
    // control pair and registers
    // ****************************************
    always_ff @(posedge pxclk) begin
        if (!rst_n) begin
            pair_half  <= 1'b0;
            frame_flag <= 1'b0;
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (ctrl_wr) begin
                pair_half <= ~pair_half;
            end else if (stat_rd || cpu.data_wr || cpu.data_rd) begin
                pair_half <= 1'b0;  // any other port access restarts the pair
            end
            if (second && cb.reg_wr.is_reg) begin
                regs[cb.reg_wr.regnum] <= first_byte;
            end
            if (stat_rd) frame_flag <= 1'b0;
            if (frame_tick) frame_flag <= 1'b1;  // a new frame wins over a clearing read
        end
    end

    always_ff @(posedge pxclk) begin
        if (ctrl_wr && !pair_half) first_byte <= din;
    end

    // address loads go straight to the VRAM pointer
    assign cpu.addr_load = second & ~cb.reg_wr.is_reg;
    assign cpu.load_addr = {cb.addr_ld.addr_hi, first_byte};
    assign cpu.load_read = ~cb.addr_ld.wr_intent;
    assign cpu.data_wr   = wr_tick & ~mode;
    assign cpu.data_rd   = rd_tick & ~mode;
    assign cpu.wdata     = din;

    assign status = {frame_flag, 7'd0};  // sprite status bits are not implemented
    assign irq    = frame_flag & regs[1][REG_IE];

    assign cfg.blank_en     = regs[1][REG_BLANK_EN];
    assign cfg.name_base    = regs[2][3:0];
    assign cfg.color_base   = regs[3];
    assign cfg.pattern_base = regs[4][2:0];
    assign cfg.fg_color     = regs[7][REG_FG_LSB +: 4];
    assign cfg.bg_color     = regs[7][REG_BG_LSB +: 4];

endmodule

/* vdp_if.sv */
// vdp internal buses between the register decoder, the VRAM and the renderer

// CPU side access into the video memory
interface vram_cpu_if ();
    logic        addr_load;  // one-cycle pointer load
    logic [13:0] load_addr;
    logic        load_read;  // refill the read-ahead after the load
    logic        data_wr;    // data port ticks
    logic        data_rd;
    logic [7:0]  wdata;
    logic [7:0]  rdata;      // read-ahead buffer contents

    modport ctrl (output addr_load, load_addr, load_read, data_wr, data_rd, wdata,
                  input rdata);
    modport mem  (input addr_load, load_addr, load_read, data_wr, data_rd, wdata,
                  output rdata);
endinterface

// decoded register fields for the display side
interface vdp_cfg_if import vdp_pkg::*; ();
    logic       blank_en;
    logic [3:0] name_base;
    logic [7:0] color_base;
    logic [2:0] pattern_base;
    color_t     fg_color;
    color_t     bg_color;

    modport src  (output blank_en, name_base, color_base, pattern_base, fg_color, bg_color);
    modport sink (input blank_en, name_base, color_base, pattern_base, fg_color, bg_color);
endinterface

/* vdp_pkg.sv */
// vdp shared definitions covering VGA geometry, register fields, colours and the control byte
package vdp_pkg;

    // ****************************************
    // VGA 640x480 timing, all in pixel clocks or lines
    // ****************************************
    localparam logic [9:0] H_TOTAL      = 10'd800;
    localparam logic [9:0] H_ACTIVE     = 10'd640;
    localparam logic [9:0] H_SYNC_START = 10'd656;
    localparam logic [9:0] H_SYNC_WIDTH = 10'd96;
    localparam logic [9:0] V_TOTAL      = 10'd525;
    localparam logic [9:0] V_ACTIVE     = 10'd480;
    localparam logic [9:0] V_SYNC_START = 10'd490;
    localparam logic [9:0] V_SYNC_WIDTH = 10'd2;

    // the 256x192 picture is doubled and centred, the rest of the visible area is border
    localparam logic [9:0] PIC_X0 = 10'd64;  // must stay a multiple of 16 for the cell phase
    localparam logic [9:0] PIC_Y0 = 10'd48;
    localparam logic [9:0] PIC_W  = 10'd512;
    localparam logic [9:0] PIC_H  = 10'd384;

    localparam int PIPE_DELAY = 3;  // counters to colour pin, in clocks

    // register field positions
    localparam int REG_BLANK_EN = 6;  // R1, 0 forces black
    localparam int REG_IE       = 5;  // R1, frame interrupt enable
    localparam int REG_FG_LSB   = 4;  // R7 high nibble
    localparam int REG_BG_LSB   = 0;  // R7 low nibble, also the border colour

    // table base scaling as shifts
    localparam int NAME_SHIFT    = 10;  // R2 times 1024
    localparam int COLOR_SHIFT   = 6;   // R3 times 64
    localparam int PATTERN_SHIFT = 11;  // R4 times 2048

    typedef logic [3:0] color_t;  // palette index

    // second control byte, bit 7 picks which view applies
    typedef struct packed {
        logic       is_reg;  // 1 for a register write
        logic [3:0] pad;
        logic [2:0] regnum;
    } ctrl_reg_t;

    typedef struct packed {
        logic       is_reg;     // 0 for an address load
        logic       wr_intent;  // 0 asks for a read-ahead
        logic [5:0] addr_hi;
    } ctrl_addr_t;

    typedef union packed {
        ctrl_reg_t  reg_wr;
        ctrl_addr_t addr_ld;
    } ctrl_byte_u;

endpackage
